// File: verilog/bus_pkg.sv
package bus_pkg;

  // data and address word of the memory bus.
  typedef logic [31:0] word_t;

  // one strobe bit per byte lane.
  typedef logic [3:0] strb_t;

  typedef logic [7:0] byte_t;

endpackage

// File: verilog/soc_map_pkg.sv
package soc_map_pkg;

  // the top bound of each peripheral window is exclusive.
  localparam logic [31:0] uart_base_addr = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr = 32'h1000_0010;

  localparam logic [31:0] timer_base_addr = 32'h2000_0000;
  localparam logic [31:0] timer_top_addr = 32'h2000_0010;

  // uart register offsets inside its window.
  localparam logic [3:0] uart_txdata_ofs = 4'h0;
  localparam logic [3:0] uart_rxdata_ofs = 4'h4;
  localparam logic [3:0] uart_status_ofs = 4'h8;

  // each 64-bit timer register is split into two 32-bit halves.
  localparam logic [3:0] timer_mtime_lo_ofs = 4'h0;
  localparam logic [3:0] timer_mtime_hi_ofs = 4'h4;
  localparam logic [3:0] timer_cmp_lo_ofs = 4'h8;
  localparam logic [3:0] timer_cmp_hi_ofs = 4'hc;

endpackage

// File: verilog/mem_if.sv
`timescale 1ns/1ns

interface mem_if
  import bus_pkg::*;
();

  logic  valid;
  word_t addr;
  word_t wdata;
  strb_t wstrb;
  word_t rdata;
  logic  ready;

  modport master (output valid, addr, wdata, wstrb, input rdata, ready);

  modport slave (input valid, addr, wdata, wstrb, output rdata, ready);

endinterface

// File: verilog/uart_tx.sv
`timescale 1ns/1ns

module uart_tx
  import bus_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  byte_t data,
  output logic  busy,
  output logic  tx
);

  localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);

  logic [cnt_w-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic [8:0]       shreg;

  // bit 0 of the frame is the start bit, driven straight away; bit 9 is the stop bit.
  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      tx <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy <= 1'b1;
        tx <= 1'b0;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end else begin
        tx <= shreg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shreg <= {1'b1, data};
    end else if (busy && clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

  // the register block must hold a new byte back until the frame is done.
  assert property (@(posedge clk) disable iff (!rst) start |-> !busy);

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ns

module uart_rx
  import bus_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  rx,
  output byte_t data,
  output logic  done
);

  localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);
  localparam int half_bit = (CLKS_PER_BIT / 2 > 0) ? CLKS_PER_BIT / 2 : 1;

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t           state;
  logic [cnt_w-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  byte_t            shreg;

  assign data = shreg;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      done <= 1'b0;
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (rx_prev && !rx_sync) begin
            state <= st_start;
            clk_cnt <= '0;
          end
        end
        // half a bit in, the line must still be low or the edge was a glitch.
        st_start: begin
          if (clk_cnt == cnt_w'(half_bit - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state <= rx_sync ? st_idle : st_data;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        st_data: begin
          if (clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            state <= st_idle;
            done <= rx_sync;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // data bits arrive LSB first and shift in from the top.
  always_ff @(posedge clk) begin
    if (state == st_data && clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
  end

endmodule

// File: verilog/uart_periph.sv
`timescale 1ns/1ns

module uart_periph
  import bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic clk,
  input  logic rst,
  mem_if.slave bus,
  input  logic rx,
  output logic tx
);

  logic       accept;
  logic       is_wr;
  logic [3:0] ofs;
  logic       tx_wr;
  logic       tx_start;
  logic       tx_busy;
  logic       stall;
  logic       rx_rd;
  logic       rx_done;
  byte_t      rx_data;
  byte_t      rx_hold;
  logic       rx_full;
  word_t      rd_next;

  assign accept = bus.valid && !bus.ready;
  assign is_wr = |bus.wstrb;
  assign ofs = bus.addr[3:0];
  assign tx_wr = accept && is_wr && (ofs == uart_txdata_ofs);
  assign tx_start = tx_wr && !tx_busy;
  // a TX write waits here until the current frame has left.
  assign stall = tx_wr && tx_busy;
  assign rx_rd = accept && !is_wr && (ofs == uart_rxdata_ofs);

  always_ff @(posedge clk) begin
    if (!rst) begin
      bus.ready <= 1'b0;
      rx_full <= 1'b0;
    end else begin
      bus.ready <= accept && !stall;
      if (rx_rd) begin
        rx_full <= 1'b0;
      end
      // a byte that finds the holding register full is lost.
      if (rx_done && !rx_full) begin
        rx_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_done && !rx_full) begin
      rx_hold <= rx_data;
    end
    if (accept) begin
      bus.rdata <= rd_next;
    end
  end

  always_comb begin
    case (ofs)
      uart_rxdata_ofs: rd_next = rx_full ? {23'b0, 1'b1, rx_hold} : '0;
      uart_status_ofs: rd_next = {30'b0, rx_full, tx_busy};
      default:         rd_next = '0;
    endcase
  end

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
    .clk   (clk),
    .rst   (rst),
    .start (tx_start),
    .data  (bus.wdata[7:0]),
    .busy  (tx_busy),
    .tx    (tx)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
    .clk  (clk),
    .rst  (rst),
    .rx   (rx),
    .data (rx_data),
    .done (rx_done)
  );

endmodule

// File: verilog/bram_store.sv
`timescale 1ns/1ns

module bram_store
  import bus_pkg::*;
#(
  parameter int BRAM_DEPTH = 1024
) (
  input logic  clk,
  input logic  rst,
  mem_if.slave bus
);

  localparam int idx_w = (BRAM_DEPTH > 1) ? $clog2(BRAM_DEPTH) : 1;

  word_t mem [BRAM_DEPTH];

  logic [idx_w-1:0] idx;
  logic             accept;

  // the depth is a power of two, so the low index bits give the word index modulo depth.
  assign idx = bus.addr[idx_w+1:2];
  assign accept = bus.valid && !bus.ready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wstrb[i]) begin
          mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      bus.rdata <= mem[idx];
    end
  end

endmodule

// File: verilog/timer_unit.sv
`timescale 1ns/1ns

module timer_unit
  import soc_map_pkg::*;
#(
  parameter int RTC_DIV = 3
) (
  input  logic clk,
  input  logic rst,
  mem_if.slave bus,
  output logic irpt
);

  localparam int cnt_w = $clog2(RTC_DIV + 1);

  logic [cnt_w-1:0] rtc_cnt;
  logic             rtc;
  logic             rtc_q;
  logic             rtc_rise;
  logic [63:0]      mtime;
  logic [63:0]      mtimecmp;
  logic             accept;
  logic             wr;
  logic [3:0]       ofs;
  logic [31:0]      rd_next;

  assign accept = bus.valid && !bus.ready;
  assign wr = accept && (|bus.wstrb);
  assign ofs = bus.addr[3:0];
  assign rtc_rise = rtc && !rtc_q;

  // rtc toggles every RTC_DIV clocks.
  always_ff @(posedge clk) begin
    if (!rst) begin
      rtc_cnt <= '0;
      rtc <= 1'b0;
      rtc_q <= 1'b0;
    end else begin
      rtc_q <= rtc;
      if (rtc_cnt == cnt_w'(RTC_DIV - 1)) begin
        rtc_cnt <= '0;
        rtc <= !rtc;
      end else begin
        rtc_cnt <= rtc_cnt + 1'b1;
      end
    end
  end

  // a bus write to mtime wins over the tick in the same cycle.
  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime <= '0;
      mtimecmp <= '1;
      irpt <= 1'b0;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= accept;
      irpt <= (mtime >= mtimecmp);
      if (wr && ofs == timer_mtime_lo_ofs) begin
        mtime[31:0] <= bus.wdata;
      end else if (wr && ofs == timer_mtime_hi_ofs) begin
        mtime[63:32] <= bus.wdata;
      end else if (rtc_rise) begin
        mtime <= mtime + 64'd1;
      end
      if (wr && ofs == timer_cmp_lo_ofs) begin
        mtimecmp[31:0] <= bus.wdata;
      end
      if (wr && ofs == timer_cmp_hi_ofs) begin
        mtimecmp[63:32] <= bus.wdata;
      end
    end
  end

  always_comb begin
    case (ofs)
      timer_mtime_lo_ofs: rd_next = mtime[31:0];
      timer_mtime_hi_ofs: rd_next = mtime[63:32];
      timer_cmp_lo_ofs:   rd_next = mtimecmp[31:0];
      timer_cmp_hi_ofs:   rd_next = mtimecmp[63:32];
      default:            rd_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bus.rdata <= rd_next;
    end
  end

endmodule

// File: verilog/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder
  import soc_map_pkg::*;
(
  input logic   clk,
  input logic   rst,
  mem_if.slave  host,
  mem_if.master ram,
  mem_if.master uart,
  mem_if.master timer
);

  logic sel_uart;
  logic sel_timer;

  assign sel_uart = (host.addr >= uart_base_addr) && (host.addr < uart_top_addr);
  assign sel_timer = (host.addr >= timer_base_addr) && (host.addr < timer_top_addr);

  // anything outside the peripheral windows lands in the RAM.
  always_comb begin
    ram.valid = host.valid && !sel_uart && !sel_timer;
    uart.valid = host.valid && sel_uart;
    timer.valid = host.valid && !sel_uart && sel_timer;
  end

  always_comb begin
    ram.addr = host.addr;
    ram.wdata = host.wdata;
    ram.wstrb = host.wstrb;
    uart.addr = host.addr;
    uart.wdata = host.wdata;
    uart.wstrb = host.wstrb;
    timer.addr = host.addr;
    timer.wdata = host.wdata;
    timer.wstrb = host.wstrb;
  end

  always_comb begin
    if (ram.ready) begin
      host.rdata = ram.rdata;
      host.ready = 1'b1;
    end else if (uart.ready) begin
      host.rdata = uart.rdata;
      host.ready = 1'b1;
    end else if (timer.ready) begin
      host.rdata = timer.rdata;
      host.ready = 1'b1;
    end else begin
      host.rdata = '0;
      host.ready = 1'b0;
    end
  end

  // only the addressed slave ever sees valid, so two answers at once mean a broken slave.
  assert property (@(posedge clk) disable iff (!rst)
    $onehot0({ram.ready, uart.ready, timer.ready}));

  assert property (@(posedge clk) disable iff (!rst) host.ready |-> host.valid);

endmodule

// File: verilog/soc_periph.sv
`timescale 1ns/1ns

module soc_periph
  import bus_pkg::*;
#(
  parameter int BRAM_DEPTH = 1024,
  parameter int CLKS_PER_BIT = 8,
  parameter int RTC_DIV = 3
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  memory_valid,
  input  word_t memory_addr,
  input  word_t memory_wdata,
  input  strb_t memory_wstrb,
  output word_t memory_rdata,
  output logic  memory_ready,
  input  logic  rx,
  output logic  tx,
  output logic  timer_irpt
);

  mem_if host_bus ();
  mem_if ram_bus ();
  mem_if uart_bus ();
  mem_if timer_bus ();

  assign host_bus.valid = memory_valid;
  assign host_bus.addr = memory_addr;
  assign host_bus.wdata = memory_wdata;
  assign host_bus.wstrb = memory_wstrb;
  assign memory_rdata = host_bus.rdata;
  assign memory_ready = host_bus.ready;

  bus_decoder bus_decoder_inst (
    .clk   (clk),
    .rst   (rst),
    .host  (host_bus.slave),
    .ram   (ram_bus.master),
    .uart  (uart_bus.master),
    .timer (timer_bus.master)
  );

  bram_store #(.BRAM_DEPTH(BRAM_DEPTH)) bram_store_inst (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.slave)
  );

  timer_unit #(.RTC_DIV(RTC_DIV)) timer_unit_inst (
    .clk  (clk),
    .rst  (rst),
    .bus  (timer_bus.slave),
    .irpt (timer_irpt)
  );

  uart_periph #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_periph_inst (
    .clk (clk),
    .rst (rst),
    .bus (uart_bus.slave),
    .rx  (rx),
    .tx  (tx)
  );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset is active low and held for two rising edges.
  initial begin
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;
  end

endmodule

// File: dv/tb_soc_periph.sv
`timescale 1ns/1ns

module tb_soc_periph
  import bus_pkg::*;
  import soc_map_pkg::*;
();

  localparam int BRAM_DEPTH = 1024;
  localparam int CLKS_PER_BIT = 8;
  localparam int RTC_DIV = 3;
  localparam int bus_timeout = 200;
  localparam word_t bram_base = 32'h0000_0100;
  localparam word_t cmp_value = 32'd16;

  logic  clk;
  logic  rst;
  logic  memory_valid;
  word_t memory_addr;
  word_t memory_wdata;
  strb_t memory_wstrb;
  word_t memory_rdata;
  logic  memory_ready;
  logic  rx;
  logic  tx;
  logic  timer_irpt;

  int    error_count = 0;
  int    timeout_count = 0;
  word_t lfsr_state = 32'hfaa109e1;

  tb_clock_gen clock_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  soc_periph #(
    .BRAM_DEPTH   (BRAM_DEPTH),
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .RTC_DIV      (RTC_DIV)
  ) soc_periph_inst (
    .clk          (clk),
    .rst          (rst),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready),
    .rx           (rx),
    .tx           (tx),
    .timer_irpt   (timer_irpt)
  );

  // taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_bits(int n);
    word_t val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], next_bit()};
    end
    return val;
  endfunction

  function automatic word_t uart_addr(logic [3:0] ofs);
    return uart_base_addr + {28'b0, ofs};
  endfunction

  function automatic word_t timer_addr(logic [3:0] ofs);
    return timer_base_addr + {28'b0, ofs};
  endfunction

  task automatic check(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      error_count++;
    end
  endtask

  // ready is sampled on the falling edge, half a cycle after the slave registered it.
  task automatic bus_access(input word_t addr, input word_t wdata, input strb_t strb,
                            output word_t rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(posedge clk);
    #1;
    memory_valid = 1'b1;
    memory_addr = addr;
    memory_wdata = wdata;
    memory_wstrb = strb;
    @(negedge clk);
    while (!memory_ready && waited < bus_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (memory_ready) begin
      rdata = memory_rdata;
    end else begin
      $display("bus access to 0x%08h got no ready in %0d cycles", addr, bus_timeout);
      timeout_count++;
    end
    @(posedge clk);
    #1;
    memory_valid = 1'b0;
    memory_wstrb = '0;
  endtask

  task automatic bus_write(input word_t addr, input word_t data, input strb_t strb);
    word_t unused_rdata;
    bus_access(addr, data, strb, unused_rdata);
  endtask

  task automatic bus_read(input word_t addr, output word_t data);
    bus_access(addr, '0, '0, data);
  endtask

  // frame bit 0 is the start bit and bit 9 the stop bit.
  task automatic capture_frame(output logic [9:0] frame);
    int waited;
    waited = 0;
    frame = '1;
    @(negedge clk);
    while (tx && waited < 4 * 10 * CLKS_PER_BIT) begin
      @(negedge clk);
      waited++;
    end
    if (tx) begin
      $display("tx line never dropped for a start bit");
      timeout_count++;
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (int i = 0; i < 10; i++) begin
        frame[i] = tx;
        if (i < 9) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
        end
      end
    end
  endtask

  task automatic send_frame(input byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
    end
    rx = 1'b1;
  endtask

  task automatic test_bram();
    word_t model [16];
    word_t data;
    strb_t strb;
    word_t rdata;
    for (int i = 0; i < 16; i++) begin
      model[i] = rand_bits(32);
      bus_write(bram_base + 4 * i, model[i], 4'hf);
    end
    for (int i = 0; i < 16; i++) begin
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      // an empty strobe would turn the access into a read.
      if (strb == '0) begin
        strb = 4'b0001;
      end
      bus_write(bram_base + 4 * i, data, strb);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model[i][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(bram_base + 4 * i, rdata);
      check("test_bram", model[i], rdata);
    end
  endtask

  task automatic test_default_region();
    word_t data;
    word_t rdata;
    data = rand_bits(32);
    bus_write(32'((BRAM_DEPTH + 5) * 4), data, 4'hf);
    bus_read(32'(((BRAM_DEPTH + 5) % BRAM_DEPTH) * 4), rdata);
    check("test_default_region near", data, rdata);
    // word index 0x0c00_0004 folds down to word 4.
    data = rand_bits(32);
    bus_write(32'h3000_0010, data, 4'hf);
    bus_read(32'((32'h0c00_0004 % BRAM_DEPTH) * 4), rdata);
    check("test_default_region far", data, rdata);
  endtask

  task automatic test_uart_tx();
    byte_t      b0;
    byte_t      b1;
    word_t      status;
    logic [9:0] frame0;
    logic [9:0] frame1;
    b0 = 8'(rand_bits(8));
    b1 = 8'(rand_bits(8));
    fork
      begin
        bus_write(uart_addr(uart_txdata_ofs), 32'(b0), 4'b0001);
        bus_read(uart_addr(uart_status_ofs), status);
        check("test_uart_tx busy", 32'd1, 32'(status[0]));
        bus_write(uart_addr(uart_txdata_ofs), 32'(b1), 4'b0001);
      end
      begin
        capture_frame(frame0);
        capture_frame(frame1);
      end
    join
    check("test_uart_tx frame 0", 32'({1'b1, b0, 1'b0}), 32'(frame0));
    check("test_uart_tx frame 1", 32'({1'b1, b1, 1'b0}), 32'(frame1));
  endtask

  task automatic test_uart_rx();
    byte_t b;
    word_t rdata;
    int    polls;
    b = 8'(rand_bits(8));
    send_frame(b);
    rdata = '0;
    polls = 0;
    while (!rdata[1] && polls < 50) begin
      bus_read(uart_addr(uart_status_ofs), rdata);
      polls++;
    end
    if (!rdata[1]) begin
      $display("UART status never showed a received byte");
      timeout_count++;
    end
    bus_read(uart_addr(uart_rxdata_ofs), rdata);
    check("test_uart_rx data", 32'h0000_0100 | 32'(b), rdata);
    bus_read(uart_addr(uart_rxdata_ofs), rdata);
    check("test_uart_rx empty", 32'd0, rdata);
  endtask

  task automatic test_timer();
    word_t lo;
    word_t hi;
    int    waited;
    check("test_timer irpt after reset", 32'd0, 32'(timer_irpt));
    bus_write(timer_addr(timer_mtime_hi_ofs), 32'd0, 4'hf);
    bus_write(timer_addr(timer_mtime_lo_ofs), 32'd0, 4'hf);
    bus_write(timer_addr(timer_cmp_hi_ofs), 32'd0, 4'hf);
    bus_write(timer_addr(timer_cmp_lo_ofs), cmp_value, 4'hf);
    bus_read(timer_addr(timer_cmp_lo_ofs), lo);
    check("test_timer mtimecmp", cmp_value, lo);
    waited = 0;
    while (!timer_irpt && waited < 4 * RTC_DIV * 32) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!timer_irpt) begin
      $display("timer interrupt never rose");
      timeout_count++;
    end
    bus_read(timer_addr(timer_mtime_lo_ofs), lo);
    bus_read(timer_addr(timer_mtime_hi_ofs), hi);
    check("test_timer mtime reached", 32'd1, 32'({hi, lo} >= 64'(cmp_value)));
    bus_write(timer_addr(timer_cmp_hi_ofs), 32'hffff_ffff, 4'hf);
    repeat (2) @(posedge clk);
    #1;
    check("test_timer irpt cleared", 32'd0, 32'(timer_irpt));
  endtask

  initial begin
    int waited;
    memory_valid = 1'b0;
    memory_addr = '0;
    memory_wdata = '0;
    memory_wstrb = '0;
    rx = 1'b1;
    waited = 0;
    while (rst !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst !== 1'b1) begin
      $display("reset was never released");
      timeout_count++;
    end
    test_bram();
    test_default_region();
    test_uart_tx();
    test_uart_rx();
    test_timer();
    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: compile.f
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/mem_if.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_periph.sv
verilog/bram_store.sv
verilog/timer_unit.sv
verilog/bus_decoder.sv
verilog/soc_periph.sv
dv/tb_clock_gen.sv
dv/tb_soc_periph.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -qx "Regression passed" $(LOG) || { echo "FAIL: no pass line in $(LOG)"; exit 1; }
	@echo "PASS: $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
